/* sources.f */
design/fdcPkg.sv
design/driveSelect.sv
design/headStepper.sv
design/bitStreamer.sv
design/readDeserializer.sv
design/floppyEmulator.sv
bench/floppyEmulatorTb.sv

/* Makefile */
VERILATOR ?= verilator
TOP := floppyEmulatorTb
RTL_TOP := floppyEmulator
FILELIST := sources.f
BUILD_DIR := obj_dir
SIM_FLAGS := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))

.PHONY: all run lint clean

all: run

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/floppyEmulatorTb.sv */
/*
 * floppy emulator testbench
 * directed tests for drive control, head stepping and the track read path,
 * with a disk image RAM model filled from an LCG of the address
 */
`timescale 1ns/1ps
`default_nettype none

module floppyEmulatorTb;

	localparam int TbTrackLen = 4;
	localparam int TbSyncGap = 50;
	localparam int CellCycles = 115;
	localparam int MaxTrack = 78;
	localparam logic [17:0] BytesPerTrack = 18'h4D0;
	localparam logic [31:0] LcgSeed = 32'h6ed7_c44a;
	localparam int PollRiseLimit = 400;
	localparam int FetchLimit = 2000;

	logic FDC_CLK;
	logic RESET_N;
	logic [1:0] sw;
	logic [7:0] fdcCt;
	logic fdcIoData;
	logic [7:0] ramDataR = 8'h00;
	wire logic ramRead;
	wire logic [17:0] ramAddr;
	wire logic [7:0] fdcData;
	wire logic fdcPoll;
	wire logic fdcWp;
	wire logic drive1;
	wire logic drive2;
	wire logic motor;
	wire logic [7:0] track1No;
	wire logic [7:0] track2No;

	// head model with drive 1 at index 0
	logic [1:0] modelPos [2];
	logic [7:0] modelTrack [2];
	int errorCount;

	floppyEmulator #(
		.TrackLen(12'(TbTrackLen)),
		.SyncGapLen(TbSyncGap)
	) dut_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.sw(sw),
		.fdcCt(fdcCt),
		.fdcIoData(fdcIoData),
		.ramDataR(ramDataR),
		.ramRead(ramRead),
		.ramAddr(ramAddr),
		.fdcData(fdcData),
		.fdcPoll(fdcPoll),
		.fdcWp(fdcWp),
		.drive1(drive1),
		.drive2(drive2),
		.motor(motor),
		.track1No(track1No),
		.track2No(track2No)
	);

	initial
	begin
		FDC_CLK = 1'b0;
		forever #10 FDC_CLK = ~FDC_CLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// disk image model
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [7:0] imageByte(input logic [17:0] addr);
		logic [31:0] state;
		state = lcgNext(LcgSeed ^ {14'd0, addr});
		state = lcgNext(state);
		return state[31:24];
	endfunction

	// byte ready one cycle after the fetch
	always @(negedge FDC_CLK)
	begin
		if (ramRead)
			ramDataR <= imageByte(ramAddr);
	end

	////////////////////////////////////////////////////////////////////////////
	// helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic reportFailure(input string msg);
		errorCount++;
		$display("%s", msg);
		$display("Some tests failed");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic compareValue(input string name, input logic [31:0] got,
		input logic [31:0] expected);
		assert (got === expected)
		else
			reportFailure($sformatf("[ERROR] %s: expected 0x%0h, got 0x%0h",
				name, expected, got));
	endtask

	function automatic logic expectedWp(input logic [1:0] drives, input logic [1:0] sws);
		// drives[0] is drive 1 and takes priority
		if (drives[0])
			return ~sws[0];
		else if (drives[1])
			return ~sws[1];
		return 1'b1;
	endfunction

	function automatic logic [17:0] expectedBase(input int drv, input logic [7:0] track);
		logic [17:0] base;
		base = {10'd0, track} * BytesPerTrack;
		if (drv == 1)
			base = base | 18'h20000;
		return base;
	endfunction

	function automatic logic [7:0] driveBits(input int drv);
		return (drv == 0) ? 8'h10 : 8'h80;
	endfunction

	task automatic compareTracks();
		compareValue("track1No", 32'(track1No), 32'(modelTrack[0]));
		compareValue("track2No", 32'(track2No), 32'(modelTrack[1]));
	endtask

	// park the phases before the drive bits change
	task automatic selectDrives(input logic [7:0] newCt);
		fdcCt = fdcCt & 8'hF0;
		repeat (4) @(negedge FDC_CLK);
		fdcCt = newCt;
		repeat (4) @(negedge FDC_CLK);
	endtask

	task automatic stepHead(input int drv, input bit forward);
		logic [1:0] target;
		if (forward)
			target = modelPos[drv] + 2'd1;
		else
			target = modelPos[drv] - 2'd1;
		fdcCt = driveBits(drv) | (8'h01 << target);
		repeat (4) @(negedge FDC_CLK);
		if (forward && (modelTrack[drv] < 8'(MaxTrack)))
		begin
			modelTrack[drv] = modelTrack[drv] + 8'd1;
			modelPos[drv] = target;
		end
		else if (!forward && (modelTrack[drv] > 8'd0))
		begin
			modelTrack[drv] = modelTrack[drv] - 8'd1;
			modelPos[drv] = target;
		end
		compareTracks();
	endtask

	// phase that must not move the head
	task automatic holdPhase(input int drv, input logic [3:0] phaseBits);
		fdcCt = driveBits(drv) | {4'b0000, phaseBits};
		repeat (4) @(negedge FDC_CLK);
		compareTracks();
	endtask

	task automatic nextRamRead();
		int cycles;
		cycles = 0;
		@(negedge FDC_CLK);
		while (ramRead !== 1'b1)
		begin
			cycles++;
			if (cycles > FetchLimit)
				reportFailure("timeout: the DUT issued no ramRead pulse");
			@(negedge FDC_CLK);
		end
	endtask

	task automatic nextPollRise();
		int cycles;
		logic sawLow;
		logic done;
		cycles = 0;
		sawLow = 1'b0;
		done = 1'b0;
		while (!done)
		begin
			@(negedge FDC_CLK);
			cycles++;
			if (fdcPoll === 1'b0)
				sawLow = 1'b1;
			else if (sawLow)
				done = 1'b1;
			if (!done && (cycles > PollRiseLimit))
				reportFailure("timeout: fdcPoll did not rise at a cell start");
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic driveControlCases();
		logic [1:0] drives;
		for (int d = 0; d < 4; d++)
		begin
			for (int s = 0; s < 4; s++)
			begin
				drives = 2'(d);
				sw = 2'(s);
				fdcCt = {drives[1], 2'b00, drives[0], 4'b0000};
				repeat (2) @(negedge FDC_CLK);
				compareValue("drive1", 32'(drive1), 32'(drives[0]));
				compareValue("drive2", 32'(drive2), 32'(drives[1]));
				compareValue("motor", 32'(motor), 32'(drives[0] | drives[1]));
				compareValue("fdcWp", 32'(fdcWp), 32'(expectedWp(drives, sw)));
			end
		end
	endtask

	task automatic stepHeadInOut();
		logic [1:0] skipPos;
		selectDrives(8'h10);
		repeat (5) stepHead(0, 1'b1);
		compareValue("track1No", 32'(track1No), 5);
		compareValue("track2No", 32'(track2No), 0);
		// two extra steps hit the lower clamp
		repeat (7) stepHead(0, 1'b0);
		compareValue("track1No", 32'(track1No), 0);
		stepHead(0, 1'b1);
		skipPos = modelPos[0] + 2'd2;
		holdPhase(0, 4'b0001 << skipPos);
		holdPhase(0, 4'b0001 << modelPos[0]);
		stepHead(0, 1'b0);
	endtask

	task automatic climbToUpperLimit();
		selectDrives(8'h80);
		repeat (82) stepHead(1, 1'b1);
		compareValue("track2No", 32'(track2No), MaxTrack);
		compareValue("track1No", 32'(track1No), 0);
	endtask

	task automatic readTrackStream();
		logic [17:0] base;
		logic [17:0] fetchAddr;
		int tries;
		selectDrives(8'h10);
		repeat (3) stepHead(0, 1'b1);
		base = expectedBase(0, modelTrack[0]);
		// line up on the fetch of the first track byte
		tries = 0;
		nextRamRead();
		while (ramAddr !== base)
		begin
			tries++;
			if (tries > 16)
				reportFailure("the first byte of the track was never fetched");
			nextRamRead();
		end
		fetchAddr = ramAddr;
		for (int k = 0; k < TbTrackLen; k++)
		begin
			// seven more cells of this byte and a strobe late in the last one
			for (int n = 0; n < 7; n++)
				nextPollRise();
			repeat (80) @(negedge FDC_CLK);
			fdcIoData = 1'b1;
			@(negedge FDC_CLK);
			fdcIoData = 1'b0;
			compareValue("fdcData", 32'(fdcData), 32'(imageByte(fetchAddr)));
			nextRamRead();
			compareValue("ramAddr", 32'(ramAddr),
				32'(base + 18'((k + 1) % TbTrackLen)));
			fetchAddr = ramAddr;
		end
	endtask

	task automatic drive2AndIdle();
		logic [17:0] base2;
		selectDrives(8'h80);
		base2 = expectedBase(1, modelTrack[1]);
		nextRamRead();
		compareValue("ramAddr[17]", 32'(ramAddr[17]), 1);
		compareValue("ramAddr track part", 32'(ramAddr & 18'h3FFF0), 32'(base2));
		selectDrives(8'h00);
		repeat (2 * CellCycles)
		begin
			@(negedge FDC_CLK);
			compareValue("fdcPoll", 32'(fdcPoll), 0);
			compareValue("fdcData", 32'(fdcData), 32'hFF);
		end
		compareValue("fdcWp", 32'(fdcWp), 1);
		compareValue("motor", 32'(motor), 0);
	endtask

	initial
	begin
		errorCount = 0;
		RESET_N = 1'b0;
		sw = 2'b00;
		fdcCt = 8'h00;
		fdcIoData = 1'b0;
		modelPos[0] = 2'd0;
		modelPos[1] = 2'd0;
		modelTrack[0] = 8'd0;
		modelTrack[1] = 8'd0;
		repeat (16) @(negedge FDC_CLK);
		compareValue("ramRead", 32'(ramRead), 0);
		compareValue("fdcPoll", 32'(fdcPoll), 0);
		compareValue("drive1", 32'(drive1), 0);
		compareValue("drive2", 32'(drive2), 0);
		compareValue("motor", 32'(motor), 0);
		compareTracks();
		RESET_N = 1'b1;
		@(negedge FDC_CLK);

		driveControlCases();
		stepHeadInOut();
		climbToUpperLimit();
		readTrackStream();
		drive2AndIdle();

		if (errorCount == 0)
		begin
			$display("All tests passed");
			$finish;
		end
		else
		begin
			$display("Some tests failed");
			$fatal(1, "simulation ended with failed checks");
		end
	end

endmodule

`default_nettype wire

/* design/floppyEmulator.sv */
/*
 * two drive floppy emulator top level
 * drive select, head steppers and the track read path on one RAM image
 */
`timescale 1ns/1ps
`default_nettype none

module floppyEmulator #(
	parameter fdcPkg::byteIndex_t TrackLen = 12'h9A0,
	parameter int SyncGapLen = 262144
) (
	input wire logic FDC_CLK,
	input wire logic RESET_N,
	input wire logic [1:0] sw,
	input wire logic [7:0] fdcCt,
	input wire logic fdcIoData,
	input wire logic [7:0] ramDataR,
	output wire logic ramRead,
	output wire fdcPkg::ramAddr_t ramAddr,
	output wire logic [7:0] fdcData,
	output wire logic fdcPoll,
	output wire logic fdcWp,
	output wire logic drive1,
	output wire logic drive2,
	output wire logic motor,
	output wire fdcPkg::trackNo_t track1No,
	output wire fdcPkg::trackNo_t track2No
);
	import fdcPkg::*;

	wire logic [3:0] phase;
	wire logic step1En;
	wire logic step2En;
	wire logic driveActive;
	wire ramAddr_t trackBase;
	wire trackOffset_t track1Offset;
	wire trackOffset_t track2Offset;
	wire logic poll;
	wire logic fdcRec;
	wire logic dataSet;

	////////////////////////////////////////////////////////////////////////////
	// drive mechanics
	////////////////////////////////////////////////////////////////////////////

	driveSelect select_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.fdcCt(fdcCt),
		.sw(sw),
		.track1Offset(track1Offset),
		.track2Offset(track2Offset),
		.drive1(drive1),
		.drive2(drive2),
		.motor(motor),
		.fdcWp(fdcWp),
		.phase(phase),
		.step1En(step1En),
		.step2En(step2En),
		.driveActive(driveActive),
		.trackBase(trackBase)
	);

	headStepper stepper1_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.stepEn(step1En),
		.phase(phase),
		.trackNo(track1No),
		.trackOffset(track1Offset)
	);

	headStepper stepper2_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.stepEn(step2En),
		.phase(phase),
		.trackNo(track2No),
		.trackOffset(track2Offset)
	);

	////////////////////////////////////////////////////////////////////////////
	// read path
	////////////////////////////////////////////////////////////////////////////

	bitStreamer #(
		.TrackLen(TrackLen),
		.SyncGapLen(SyncGapLen)
	) streamer_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.trackBase(trackBase),
		.ramDataR(ramDataR),
		.ramRead(ramRead),
		.ramAddr(ramAddr),
		.poll(poll),
		.fdcRec(fdcRec),
		.dataSet(dataSet)
	);

	readDeserializer deserializer_i (
		.FDC_CLK(FDC_CLK),
		.RESET_N(RESET_N),
		.poll(poll),
		.fdcRec(fdcRec),
		.dataSet(dataSet),
		.fdcIoData(fdcIoData),
		.driveActive(driveActive),
		.fdcPoll(fdcPoll),
		.fdcData(fdcData)
	);

endmodule

`default_nettype wire

/* design/readDeserializer.sv */
/*
 * host side read deserializer
 * recovers bits from the record pulses, assembles bytes, latches on strobe
 */
`timescale 1ns/1ps
`default_nettype none

module readDeserializer (
	input wire logic FDC_CLK,
	input wire logic RESET_N,
	input wire logic poll,
	input wire logic fdcRec,
	input wire logic dataSet,
	input wire logic fdcIoData,
	input wire logic driveActive,
	output logic fdcPoll,
	output logic [7:0] fdcData
);
	logic recQ;
	logic ioDataQ;
	logic bitVal;
	logic [7:0] shiftReg;
	logic [7:0] dataReg;

	// edge detect state
	always_ff @(posedge FDC_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			recQ <= 1'b0;
			ioDataQ <= 1'b0;
		end
		else
		begin
			recQ <= fdcRec;
			ioDataQ <= fdcIoData;
		end
	end

	always_ff @(posedge FDC_CLK)
	begin
		// clock pulse lands inside poll, data pulse after it
		if (fdcRec && !recQ)
			bitVal <= ~poll;
		if (dataSet)
			shiftReg <= {shiftReg[6:0], bitVal};
		if (fdcIoData && !ioDataQ)
			dataReg <= shiftReg;
	end

	assign fdcPoll = driveActive ? poll : 1'b0;
	assign fdcData = driveActive ? dataReg : 8'hFF;

endmodule

`default_nettype wire

/* design/bitStreamer.sv */
/*
 * track bit streamer
 * waits out the sync gap, then fetches track bytes from the disk image RAM
 * and plays them out MSB first as poll, clock and data pulses per bit cell
 */
`timescale 1ns/1ps
`default_nettype none

module bitStreamer #(
	parameter fdcPkg::byteIndex_t TrackLen = 12'h9A0,
	parameter int SyncGapLen = 262144
) (
	input wire logic FDC_CLK,
	input wire logic RESET_N,
	input wire fdcPkg::ramAddr_t trackBase,
	input wire logic [7:0] ramDataR,
	output logic ramRead,
	output fdcPkg::ramAddr_t ramAddr,
	output logic poll,
	output logic fdcRec,
	output logic dataSet
);
	import fdcPkg::*;

	localparam int SyncW = $clog2(SyncGapLen + 1);

	streamState_t state;
	logic [SyncW-1:0] syncCnt;
	logic [6:0] cycleCnt;
	byteIndex_t byteIdx;
	logic [2:0] bitIdx;

	logic inCell;
	logic cellEnd;
	logic fetchNow;
	logic clockRec;
	logic dataRec;

	////////////////////////////////////////////////////////////////////////////
	// cell decode
	////////////////////////////////////////////////////////////////////////////

	assign inCell = (state == streamCell);
	assign cellEnd = (cycleCnt == CellLen - 7'd1);

	// new byte needed once all 8 bits have gone out
	assign fetchNow = inCell && (cycleCnt == ClockRecStart) && (bitIdx == 3'd0);

	assign clockRec = (cycleCnt >= ClockRecStart) && (cycleCnt < ClockRecEnd);
	assign dataRec = (cycleCnt >= DataRecStart) && (cycleCnt < DataRecEnd) &&
		ramDataR[bitIdx];

	assign poll = inCell && (cycleCnt < PollEndCycle);
	assign fdcRec = inCell && (clockRec || dataRec);
	assign dataSet = inCell && (cycleCnt == DataSetCycle);

	////////////////////////////////////////////////////////////////////////////
	// sequencer
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge FDC_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			state <= streamSync;
			syncCnt <= '0;
			cycleCnt <= 7'd0;
			byteIdx <= '0;
			bitIdx <= 3'd0;
			ramRead <= 1'b0;
		end
		else
		begin
			ramRead <= fetchNow;
			case (state)
				streamSync:
				begin
					// silence before the first cell of the track
					if (syncCnt == SyncW'(SyncGapLen - 1))
					begin
						syncCnt <= '0;
						cycleCnt <= 7'd0;
						state <= streamCell;
					end
					else
						syncCnt <= syncCnt + SyncW'(1);
				end
				streamCell:
				begin
					// 0 wraps to 7 on a fetch
					if (cycleCnt == ClockRecStart)
						bitIdx <= bitIdx - 3'd1;
					if (fetchNow)
						byteIdx <= byteIdx + 12'd1;
					if (cellEnd)
					begin
						cycleCnt <= 7'd0;
						// last bit of the last byte, back to the gap
						if ((byteIdx == TrackLen) && (bitIdx == 3'd0))
						begin
							byteIdx <= '0;
							state <= streamSync;
						end
					end
					else
						cycleCnt <= cycleCnt + 7'd1;
				end
			endcase
		end
	end

	// read address, valid with ramRead
	always_ff @(posedge FDC_CLK)
	begin
		if (fetchNow)
			ramAddr <= trackBase + {6'd0, byteIdx};
	end

endmodule

`default_nettype wire

/* design/headStepper.sv */
/*
 * quarter step head positioner for one drive
 * follows the one-hot phase coils and keeps the track number and offset
 */
`timescale 1ns/1ps
`default_nettype none

module headStepper (
	input wire logic FDC_CLK,
	input wire logic RESET_N,
	input wire logic stepEn,
	input wire logic [3:0] phase,
	output fdcPkg::trackNo_t trackNo,
	output fdcPkg::trackOffset_t trackOffset
);
	import fdcPkg::*;

	stepPhase_t pos;
	stepPhase_t nextPos;
	stepPhase_t prevPos;
	logic [3:0] nextHot;
	logic [3:0] prevHot;
	logic stepIn;
	logic stepOut;

	// neighbouring quarters wrap around the four coils
	assign nextPos = stepPhase_t'(pos + 2'd1);
	assign prevPos = stepPhase_t'(pos - 2'd1);

	assign nextHot = 4'b0001 << nextPos;
	assign prevHot = 4'b0001 << prevPos;

	// blocked at the limits, position stays put too
	assign stepIn = stepEn && (phase == nextHot) && (trackNo < MaxTrackNo);
	assign stepOut = stepEn && (phase == prevHot) && (trackNo != 8'd0);

	always_ff @(posedge FDC_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			pos <= phaseA;
			trackNo <= 8'd0;
			trackOffset <= '0;
		end
		else if (stepIn)
		begin
			pos <= nextPos;
			trackNo <= trackNo + 8'd1;
			trackOffset <= trackOffset + TrackStep;
		end
		else if (stepOut)
		begin
			pos <= prevPos;
			trackNo <= trackNo - 8'd1;
			trackOffset <= trackOffset - TrackStep;
		end
	end

endmodule

`default_nettype wire

/* design/driveSelect.sv */
/*
 * drive select logic
 * latches the control byte, delays the stepper phases and picks the
 * active drive, its write protect level and its track base address
 */
`timescale 1ns/1ps
`default_nettype none

module driveSelect (
	input wire logic FDC_CLK,
	input wire logic RESET_N,
	input wire logic [7:0] fdcCt,
	input wire logic [1:0] sw,
	input wire fdcPkg::trackOffset_t track1Offset,
	input wire fdcPkg::trackOffset_t track2Offset,
	output logic drive1,
	output logic drive2,
	output logic motor,
	output logic fdcWp,
	output logic [3:0] phase,
	output logic step1En,
	output logic step2En,
	output logic driveActive,
	output fdcPkg::ramAddr_t trackBase
);
	import fdcPkg::*;

	logic [3:0] phaseLatch;
	logic [3:0] phaseMid;

	// control byte latch plus two phase delay stages
	always_ff @(posedge FDC_CLK or negedge RESET_N)
	begin
		if (!RESET_N)
		begin
			drive1 <= 1'b0;
			drive2 <= 1'b0;
			motor <= 1'b0;
			phaseLatch <= 4'b0000;
			phaseMid <= 4'b0000;
			phase <= 4'b0000;
		end
		else
		begin
			drive1 <= fdcCt[CtDrive1];
			drive2 <= fdcCt[CtDrive2];
			motor <= fdcCt[CtDrive1] | fdcCt[CtDrive2];
			phaseLatch <= {fdcCt[CtPhase3], fdcCt[CtPhase2], fdcCt[CtPhase1], fdcCt[CtPhase0]};
			phaseMid <= phaseLatch;
			phase <= phaseMid;
		end
	end

	// switch closed means writable, drive1 wins
	assign fdcWp = drive1 ? ~sw[0] : (drive2 ? ~sw[1] : 1'b1);

	// drive2 head also moves when nothing is selected
	assign step1En = drive1;
	assign step2En = ~drive1;

	assign driveActive = drive1 | drive2;

	// drive2 image lives in the upper half of RAM
	assign trackBase = drive1 ? {1'b0, track1Offset, 4'b0000} :
		drive2 ? {1'b1, track2Offset, 4'b0000} : '0;

endmodule

`default_nettype wire

/* design/fdcPkg.sv */
/*
 * floppy emulator common definitions
 * disk image address types, control byte layout and bit cell timing
 */
`default_nettype none

package fdcPkg;

	////////////////////////////////////////////////////////////////////////////
	// disk image addressing
	////////////////////////////////////////////////////////////////////////////

	typedef logic [17:0] ramAddr_t;
	// head position in 16 byte units
	typedef logic [12:0] trackOffset_t;
	typedef logic [7:0] trackNo_t;
	typedef logic [11:0] byteIndex_t;

	// one track is 0x4D0 bytes, so 0x4D offset units
	localparam trackOffset_t TrackStep = 13'h04D;
	// 40 tracks at half steps
	localparam trackNo_t MaxTrackNo = 8'd78;

	// controller control byte
	localparam int CtPhase0 = 0;
	localparam int CtPhase1 = 1;
	localparam int CtPhase2 = 2;
	localparam int CtPhase3 = 3;
	localparam int CtDrive1 = 4;
	localparam int CtDrive2 = 7;

	////////////////////////////////////////////////////////////////////////////
	// bit cell timing, cycles from cell start
	////////////////////////////////////////////////////////////////////////////

	localparam logic [6:0] PollEndCycle = 7'd33;
	localparam logic [6:0] ClockRecStart = 7'd32;
	localparam logic [6:0] ClockRecEnd = 7'd36;
	localparam logic [6:0] DataRecStart = 7'd60;
	localparam logic [6:0] DataSetCycle = 7'd61;
	localparam logic [6:0] DataRecEnd = 7'd64;
	localparam logic [6:0] CellLen = 7'd115;

	// track sequencer
	typedef enum logic {
		streamSync,
		streamCell
	} streamState_t;

	// stepper quarter positions, one per phase coil
	typedef enum logic [1:0] {
		phaseA,
		phaseB,
		phaseC,
		phaseD
	} stepPhase_t;

endpackage

`default_nettype wire
